// File: logic/ppu_render_pkg.sv
package ppu_render_pkg;

	// Frame buffer address is {row[7:0], col[7:0]}
	localparam int FB_ADDR_BITS = 16;

	// One aligned tile row per job
	localparam int PIXELS_PER_RUN = 8;

	// Sprite attribute bits
	localparam int ATTR_FLIP_BIT = 6;
	localparam int ATTR_BEHIND_BIT = 5;

	// Control register 2 enable bits
	localparam int CTRL_BG_EN_BIT = 3;
	localparam int CTRL_SPR_EN_BIT = 4;

	// Screen row or column, 9 bits wide
	typedef logic [8:0] vga_coord_t;

	// One palette byte per pixel
	typedef logic [7:0] pixel_t;

	// Four colour bytes, byte n picked by index n
	typedef logic [31:0] palette_word_t;

	// One plane of one tile row
	typedef logic [7:0] pattern_t;

	// Sprite source, 56 bits
	typedef struct packed {
		pattern_t pattern_low;
		pattern_t pattern_high;
		logic [7:0] attr;
		palette_word_t colors;
	} sprite_src_t;

	// Background source, 48 bits
	typedef struct packed {
		pattern_t pattern_low;
		pattern_t pattern_high;
		palette_word_t colors;
	} bg_src_t;

	// Frame buffer write payload, 26 bits, paired with a write enable level
	typedef struct packed {
		vga_coord_t row;
		vga_coord_t col;
		pixel_t data;
	} fb_write_t;

	typedef enum logic {
		RENDER_IDLE,
		RENDER_DRAW
	} render_state_t;

endpackage

// File: logic/pixel_mux.sv
`timescale 1ns/1ps

module pixel_mux import ppu_render_pkg::*; (
	input sprite_src_t spr0,
	input sprite_src_t spr1,
	input sprite_src_t spr2,
	input bg_src_t bg,
	input logic [7:0] ppu_ctrl2,
	output logic [63:0] pixel_row,
	output logic sprite_0_hit,
	output logic sprite_1_hit
);

	logic bg_en;
	logic spr_en;

	// Layer enables from control register 2
	assign bg_en = ppu_ctrl2[CTRL_BG_EN_BIT];
	assign spr_en = ppu_ctrl2[CTRL_SPR_EN_BIT];

	// Sprite index at one position
	// Unmirrored, pixel 0 is pattern bit 7
	function automatic logic [1:0] sprite_index(input sprite_src_t spr, input int pos);
		int sel;
		if (spr.attr[ATTR_FLIP_BIT]) begin
			sel = pos;
		end else begin
			sel = PIXELS_PER_RUN - 1 - pos;
		end
		// High plane is the upper index bit
		return {spr.pattern_high[sel], spr.pattern_low[sel]};
	endfunction

	// Background index, never mirrored
	function automatic logic [1:0] bg_index(input bg_src_t src, input int pos);
		int sel;
		sel = PIXELS_PER_RUN - 1 - pos;
		return {src.pattern_high[sel], src.pattern_low[sel]};
	endfunction

	// Byte n of the colour word for index n
	function automatic pixel_t color_byte(input palette_word_t colors, input logic [1:0] idx);
		return colors[{idx, 3'b000} +: 8];
	endfunction

	always_comb begin
		logic [1:0] idx0;
		logic [1:0] idx1;
		logic [1:0] idx2;
		logic [1:0] bg_idx;
		logic [1:0] spr_idx;
		logic spr_behind;
		palette_word_t spr_colors;
		pixel_t pix;

		pixel_row = '0;
		sprite_0_hit = 1'b0;
		sprite_1_hit = 1'b0;

		for (int p = 0; p < PIXELS_PER_RUN; p++) begin
			// Disabled layers read as transparent
			idx0 = spr_en ? sprite_index(spr0, p) : 2'b00;
			idx1 = spr_en ? sprite_index(spr1, p) : 2'b00;
			idx2 = spr_en ? sprite_index(spr2, p) : 2'b00;
			bg_idx = bg_en ? bg_index(bg, p) : 2'b00;

			// Lowest numbered opaque sprite claims the pixel
			// A behind sprite still hides the sprites after it
			if (idx0 != 2'b00) begin
				spr_idx = idx0;
				spr_behind = spr0.attr[ATTR_BEHIND_BIT];
				spr_colors = spr0.colors;
			end else if (idx1 != 2'b00) begin
				spr_idx = idx1;
				spr_behind = spr1.attr[ATTR_BEHIND_BIT];
				spr_colors = spr1.colors;
			end else if (idx2 != 2'b00) begin
				spr_idx = idx2;
				spr_behind = spr2.attr[ATTR_BEHIND_BIT];
				spr_colors = spr2.colors;
			end else begin
				spr_idx = 2'b00;
				spr_behind = 1'b0;
				spr_colors = '0;
			end

			// Sprite in front, or behind a transparent background
			if (spr_idx != 2'b00 && !(spr_behind && bg_idx != 2'b00)) begin
				pix = color_byte(spr_colors, spr_idx);
			end else if (bg_idx != 2'b00) begin
				pix = color_byte(bg.colors, bg_idx);
			end else begin
				// Backdrop
				pix = color_byte(bg.colors, 2'b00);
			end

			// Pixel 0 sits in the top byte
			pixel_row[(PIXELS_PER_RUN - 1 - p) * 8 +: 8] = pix;

			// Hit needs both layers opaque at the same position
			sprite_0_hit = sprite_0_hit | ((idx0 != 2'b00) && (bg_idx != 2'b00));
			sprite_1_hit = sprite_1_hit | ((idx1 != 2'b00) && (bg_idx != 2'b00));
		end
	end

endmodule

// File: logic/render_8_pixels.sv
`timescale 1ns/1ps

module render_8_pixels import ppu_render_pkg::*; (
	input logic clk,
	input logic rst,
	input vga_coord_t start_row,
	input vga_coord_t start_col,
	input logic start,
	input logic [63:0] pixel_row,
	output fb_write_t render_wr,
	output logic render_we,
	output logic busy
);

	render_state_t state;

	// Offset of the pixel now on the bus
	// start_col is held by the caller for the whole run
	vga_coord_t pos_idx;
	logic last_pos;
	logic [2:0] next_pos;

	assign pos_idx = render_wr.col - start_col;
	assign last_pos = (pos_idx == vga_coord_t'(PIXELS_PER_RUN - 1));
	assign next_pos = pos_idx[2:0] + 3'd1;

	assign busy = (state == RENDER_DRAW);

	// State and write enable
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= RENDER_IDLE;
			render_we <= 1'b0;
		end else begin
			case (state)
				RENDER_IDLE: begin
					// First write goes out on the same edge as busy
					if (start) begin
						state <= RENDER_DRAW;
						render_we <= 1'b1;
					end else begin
						render_we <= 1'b0;
					end
				end
				RENDER_DRAW: begin
					// Eighth pixel was on the bus, wrap up
					if (last_pos) begin
						state <= RENDER_IDLE;
						render_we <= 1'b0;
					end else begin
						render_we <= 1'b1;
					end
				end
				default: begin
					state <= RENDER_IDLE;
					render_we <= 1'b0;
				end
			endcase
		end
	end

	// Address and data
	always_ff @(posedge clk) begin
		if (state == RENDER_IDLE) begin
			if (start) begin
				render_wr.row <= start_row;
				render_wr.col <= start_col;
				render_wr.data <= pixel_row[PIXELS_PER_RUN * 8 - 1 -: 8];
			end
		end else if (!last_pos) begin
			render_wr.col <= render_wr.col + 1'b1;
			// ~next_pos is 7 - next_pos, the byte slot of that pixel
			render_wr.data <= pixel_row[{~next_pos, 3'b000} +: 8];
		end
	end

endmodule

// File: logic/host_pixel_writer.sv
`timescale 1ns/1ps

module host_pixel_writer import ppu_render_pkg::*; (
	input logic clk,
	input logic rst,
	input fb_write_t host_wr,
	input logic host_strobe,
	input logic host_grant,
	output logic host_req,
	output fb_write_t pend_wr,
	output logic host_busy
);

	// One entry pending flag
	logic pending;

	// Strobe only accepted into an empty slot
	logic accept;

	assign accept = host_strobe && !pending;

	// Request stays up until the arbiter takes it
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pending <= 1'b0;
		end else if (accept) begin
			pending <= 1'b1;
		end else if (host_grant) begin
			// Grant only comes while pending
			pending <= 1'b0;
		end
	end

	// Capture the write on acceptance
	// Strobes while full are dropped
	always_ff @(posedge clk) begin
		if (accept) begin
			pend_wr <= host_wr;
		end
	end

	assign host_req = pending;

	// Host sees the slot as busy while a write waits
	assign host_busy = pending;

endmodule

// File: logic/fb_write_arbiter.sv
`timescale 1ns/1ps

module fb_write_arbiter import ppu_render_pkg::*; (
	input logic clk,
	input logic rst,
	input fb_write_t render_wr,
	input logic render_we,
	input fb_write_t pend_wr,
	input logic host_req,
	output logic host_grant,
	output fb_write_t fb_wr,
	output logic fb_we
);

	// Renderer always wins
	// Host only gets a slot when the renderer is quiet
	assign host_grant = host_req && !render_we;

	// Registered write enable toward the frame buffer
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			fb_we <= 1'b0;
		end else begin
			fb_we <= render_we || host_req;
		end
	end

	// Registered winning payload
	// Holds its last value when nobody writes
	always_ff @(posedge clk) begin
		if (render_we) begin
			fb_wr <= render_wr;
		end else if (host_req) begin
			// Same cycle as host_grant
			fb_wr <= pend_wr;
		end
	end

endmodule

// File: logic/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer import ppu_render_pkg::*; (
	input logic clk,
	input fb_write_t fb_wr,
	input logic fb_we,
	input vga_coord_t rd_row,
	input vga_coord_t rd_col,
	output pixel_t rd_data
);

	localparam int HALF_BITS = FB_ADDR_BITS / 2;

	// 64K bytes, one per pixel
	pixel_t mem [0:(1 << FB_ADDR_BITS) - 1];

	logic [FB_ADDR_BITS-1:0] wr_addr;
	logic [FB_ADDR_BITS-1:0] rd_addr;

	// Top coordinate bit is dropped
	assign wr_addr = {fb_wr.row[HALF_BITS-1:0], fb_wr.col[HALF_BITS-1:0]};
	assign rd_addr = {rd_row[HALF_BITS-1:0], rd_col[HALF_BITS-1:0]};

	// Write port
	always_ff @(posedge clk) begin
		if (fb_we) begin
			mem[wr_addr] <= fb_wr.data;
		end
	end

	// Registered read, old data on a same-address write
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// File: logic/ppu_render_top.sv
`timescale 1ns/1ps

module ppu_render_top import ppu_render_pkg::*; (
	input logic clk,
	input logic rst,
	input sprite_src_t spr0,
	input sprite_src_t spr1,
	input sprite_src_t spr2,
	input bg_src_t bg,
	input logic [7:0] ppu_ctrl2,
	input vga_coord_t start_row,
	input vga_coord_t start_col,
	input logic start,
	output logic busy,
	output logic sprite_0_hit,
	output logic sprite_1_hit,
	input fb_write_t host_wr,
	input logic host_strobe,
	output logic host_busy,
	input vga_coord_t rd_row,
	input vga_coord_t rd_col,
	output pixel_t rd_data
);

	// Composed pixels, pixel 0 in the top byte
	logic [63:0] pixel_row;

	// Renderer side of the write bus
	fb_write_t render_wr;
	logic render_we;

	// Host side of the write bus
	fb_write_t pend_wr;
	logic host_req;
	logic host_grant;

	// Arbitrated write into the memory
	fb_write_t fb_wr;
	logic fb_we;

	pixel_mux i_pixel_mux (
		.spr0(spr0),
		.spr1(spr1),
		.spr2(spr2),
		.bg(bg),
		.ppu_ctrl2(ppu_ctrl2),
		.pixel_row(pixel_row),
		.sprite_0_hit(sprite_0_hit),
		.sprite_1_hit(sprite_1_hit)
	);

	render_8_pixels i_render_8_pixels (
		.clk(clk),
		.rst(rst),
		.start_row(start_row),
		.start_col(start_col),
		.start(start),
		.pixel_row(pixel_row),
		.render_wr(render_wr),
		.render_we(render_we),
		.busy(busy)
	);

	host_pixel_writer i_host_pixel_writer (
		.clk(clk),
		.rst(rst),
		.host_wr(host_wr),
		.host_strobe(host_strobe),
		.host_grant(host_grant),
		.host_req(host_req),
		.pend_wr(pend_wr),
		.host_busy(host_busy)
	);

	fb_write_arbiter i_fb_write_arbiter (
		.clk(clk),
		.rst(rst),
		.render_wr(render_wr),
		.render_we(render_we),
		.pend_wr(pend_wr),
		.host_req(host_req),
		.host_grant(host_grant),
		.fb_wr(fb_wr),
		.fb_we(fb_we)
	);

	frame_buffer i_frame_buffer (
		.clk(clk),
		.fb_wr(fb_wr),
		.fb_we(fb_we),
		.rd_row(rd_row),
		.rd_col(rd_col),
		.rd_data(rd_data)
	);

endmodule

// File: test/ppu_render_checker.sv
`timescale 1ns/1ps

module ppu_render_checker import ppu_render_pkg::*; (
	input logic clk,
	input logic rst,
	input logic busy,
	input logic host_busy,
	input logic sprite_0_hit,
	input logic sprite_1_hit,
	input pixel_t rd_data
);

	// Totals over the whole run
	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;

	// Errors since the last test was closed
	int test_errors = 0;

	// Busy pulse length in cycles
	// last_len holds the finished pulse
	int run_len;
	int last_len;

	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			run_len <= 0;
			last_len <= 0;
		end else if (busy) begin
			run_len <= run_len + 1;
		end else if (run_len != 0) begin
			// Pulse just ended
			last_len <= run_len;
			run_len <= 0;
		end
	end

	task automatic compare_value(input logic [127:0] tag, input logic [95:0] what,
			input logic [63:0] exp, input logic [63:0] act);
		if (act !== exp) begin
			$display("MISMATCH %0s %0s expected %0h actual %0h", tag, what, exp, act);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic report_failure(input logic [127:0] tag, input logic [319:0] msg);
		$display("ERROR %0s: %0s", tag, msg);
		error_count++;
		test_errors++;
	endtask

	// Flags are combinational and valid whenever the job inputs are held
	task automatic match_hits(input logic [127:0] tag, input logic e0, input logic e1);
		compare_value(tag, "sprite_0_hit", e0, sprite_0_hit);
		compare_value(tag, "sprite_1_hit", e1, sprite_1_hit);
	endtask

	task automatic match_read(input logic [127:0] tag, input pixel_t exp);
		compare_value(tag, "rd_data", exp, rd_data);
	endtask

	task automatic measure_busy(input logic [127:0] tag, input int exp);
		compare_value(tag, "busy_cycles", exp, last_len);
	endtask

	// Pending host write must wait while the renderer owns the bus
	task automatic confirm_host_held(input logic [127:0] tag);
		if (host_busy !== 1'b1) begin
			report_failure(tag, "host write was not held during the run");
		end
	endtask

	task automatic close_test(input logic [127:0] tag);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %0s ok", tag);
		end else begin
			tests_failed++;
			$display("test %0s failed with %0d errors", tag, test_errors);
		end
		test_errors = 0;
	endtask

	task automatic print_counts();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
	endtask

endmodule

// File: test/ppu_render_tb.sv
`timescale 1ns/1ps

module ppu_render_tb import ppu_render_pkg::*; ();

	// DUT ports
	logic clk;
	logic rst;
	sprite_src_t spr0;
	sprite_src_t spr1;
	sprite_src_t spr2;
	bg_src_t bg;
	logic [7:0] ppu_ctrl2;
	vga_coord_t start_row;
	vga_coord_t start_col;
	logic start;
	logic busy;
	logic sprite_0_hit;
	logic sprite_1_hit;
	fb_write_t host_wr;
	logic host_strobe;
	logic host_busy;
	vga_coord_t rd_row;
	vga_coord_t rd_col;
	pixel_t rd_data;

	// Fields of the current command line
	int fd;
	int code;
	logic [127:0] cmd;
	logic [127:0] name;
	logic [2047:0] line;
	vga_coord_t row;
	vga_coord_t col;
	logic [7:0] ctrl;
	logic [55:0] s0;
	logic [55:0] s1;
	logic [55:0] s2;
	logic [47:0] b;
	logic [63:0] exp_row;
	logic hit0;
	logic hit1;
	logic restart;
	logic host_on;
	vga_coord_t hrow;
	vga_coord_t hcol;
	pixel_t byte_val;

	ppu_render_top i_ppu_render_top (.*);

	ppu_render_checker i_checker (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Wait on busy or host_busy at falling edges
	task automatic await_level(input logic host_side, input logic level, input logic [127:0] tag);
		int n;
		logic cur;
		n = 0;
		cur = ~level;
		while (cur !== level && n < 50) begin
			@(negedge clk);
			cur = host_side ? host_busy : busy;
			n++;
		end
		if (cur !== level && host_side) begin
			i_checker.report_failure(tag, "host_busy never reached its level");
		end else if (cur !== level) begin
			i_checker.report_failure(tag, "busy never reached its level");
		end
	endtask

	// Host write stays parked on every cycle until the renderer lets go of the bus
	task automatic watch_host_hold(input logic [127:0] tag);
		int n;
		n = 0;
		while (busy === 1'b1 && n < 50) begin
			i_checker.confirm_host_held(tag);
			@(negedge clk);
			n++;
		end
	endtask

	// Registered read data is compared one cycle after the address
	task automatic read_and_compare(input logic [127:0] tag, input vga_coord_t r,
			input vga_coord_t c, input pixel_t exp);
		@(posedge clk);
		rd_row <= r;
		rd_col <= c;
		@(posedge clk);
		@(negedge clk);
		i_checker.match_read(tag, exp);
	endtask

	// Job inputs stay put until the next job
	task automatic run_render();
		@(posedge clk);
		spr0 <= s0;
		spr1 <= s1;
		spr2 <= s2;
		bg <= b;
		ppu_ctrl2 <= ctrl;
		start_row <= row;
		start_col <= col;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		await_level(1'b0, 1'b1, name);
		i_checker.match_hits(name, hit0, hit1);
		// Second start lands mid run
		if (restart) begin
			@(posedge clk);
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
		end
		if (host_on) begin
			@(posedge clk);
			host_wr <= {hrow, hcol, byte_val};
			host_strobe <= 1'b1;
			@(posedge clk);
			host_strobe <= 1'b0;
			@(negedge clk);
			watch_host_hold(name);
		end
		await_level(1'b0, 1'b0, name);
		// Pulse counter closes on the edge after busy falls
		repeat (2) @(posedge clk);
		@(negedge clk);
		// One busy cycle per pixel write
		i_checker.measure_busy(name, 8);
		if (host_on) begin
			await_level(1'b1, 1'b0, name);
		end
		// Pixel 0 is the top byte of the expected row
		for (int i = 0; i < PIXELS_PER_RUN; i++) begin
			read_and_compare(name, row, vga_coord_t'(col + i), exp_row[63 - 8 * i -: 8]);
		end
	endtask

	task automatic post_host_write();
		@(posedge clk);
		host_wr <= {row, col, byte_val};
		host_strobe <= 1'b1;
		@(posedge clk);
		host_strobe <= 1'b0;
		await_level(1'b1, 1'b1, name);
		await_level(1'b1, 1'b0, name);
	endtask

	initial begin
		code = $urandom(32'hab05);
		rst <= 1'b0;
		spr0 <= '0;
		spr1 <= '0;
		spr2 <= '0;
		bg <= '0;
		ppu_ctrl2 <= '0;
		start_row <= '0;
		start_col <= '0;
		start <= 1'b0;
		host_wr <= '0;
		host_strobe <= 1'b0;
		rd_row <= '0;
		rd_col <= '0;
		repeat (3) @(posedge clk);
		rst <= 1'b1;
		fd = $fopen("test/ppu_render_input.txt", "r");
		if (fd == 0) begin
			i_checker.report_failure("setup", "stimulus file could not be opened");
		end else begin
			while ($fscanf(fd, "%s", cmd) == 1) begin
				if (cmd == "#") begin
					code = $fgets(line, fd);
				end else if (cmd == "R") begin
					code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						name, row, col, ctrl, s0, s1, s2, b, exp_row,
						hit0, hit1, restart, host_on, hrow, hcol, byte_val);
					if (code == 16) begin
						run_render();
					end else begin
						i_checker.report_failure(name, "render line is malformed");
					end
					i_checker.close_test(name);
				end else if (cmd == "H" || cmd == "C") begin
					code = $fscanf(fd, "%s %h %h %h", name, row, col, byte_val);
					if (code != 4) begin
						i_checker.report_failure(name, "host or check line is malformed");
					end else if (cmd == "H") begin
						post_host_write();
					end else begin
						read_and_compare(name, row, col, byte_val);
					end
					i_checker.close_test(name);
				end else begin
					i_checker.report_failure(cmd, "unknown command in the stimulus file");
				end
			end
			$fclose(fd);
		end
		i_checker.print_counts();
		if (i_checker.error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: ppu_render.f
logic/ppu_render_pkg.sv
logic/pixel_mux.sv
logic/render_8_pixels.sv
logic/host_pixel_writer.sv
logic/fb_write_arbiter.sv
logic/frame_buffer.sv
logic/ppu_render_top.sv
test/ppu_render_checker.sv
test/ppu_render_tb.sv

// File: test/ppu_render_input.txt
# R name row col ctrl spr0 spr1 spr2 bg pixels_p0_first hit0 hit1 restart host hrow hcol hdata
# H name row col data, C name row col expected_data, all numbers in hex
R bg_only 005 010 08 FFFF00A3A2A1A0 FFFF00C3C2C1C0 FFFF00D3D2D1D0 A53CB3B2B1B0 B1B0B3B2B2B3B0B1 0 0 0 0 000 000 00
R priority 006 020 18 0F0040A3A2A1A0 003300C3C2C1C0 FFFF20D3D2D1D0 FB00B3B2B1B0 A1A1A1A1B1D3C2C2 1 1 0 0 000 000 00
R hit_flags 007 030 18 800000A3A2A1A0 000100C3C2C1C0 000000D3D2D1D0 8000B3B2B1B0 A1B0B0B0B0B0B0C2 1 0 0 0 000 000 00
H preset_next 008 048 5A
R busy_restart 008 040 08 FFFF00A3A2A1A0 FFFF00C3C2C1C0 FFFF00D3D2D1D0 FFFFB3B2B1B0 B3B3B3B3B3B3B3B3 0 0 1 0 000 000 00
C after_restart 008 048 5A
R host_overlap 009 050 08 FFFF00A3A2A1A0 FFFF00C3C2C1C0 FFFF00D3D2D1D0 A53CB3B2B1B0 B1B0B3B2B2B3B0B1 0 0 0 1 00A 050 77
C host_landed 00A 050 77
C render_intact 009 051 B0
R backdrop 00B 060 00 FFFF00A3A2A1A0 FFFF00C3C2C1C0 FFFF00D3D2D1D0 FFFFB3B2B1B0 B0B0B0B0B0B0B0B0 0 0 0 0 000 000 00
H alias_write 10C 170 3C
C alias_read 00C 070 3C
